// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_axi_rd_monitor
FLIST ?= flist.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "NO ERRORS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
source/rd_mon_pkg.sv
source/ar_tracker.sv
source/slave_beat_buffer.sv
source/beat_comparator.sv
source/mon_regs.sv
source/axi_rd_monitor.sv
verification/axi_rd_monitor_checker.sv
verification/tb_axi_rd_monitor.sv

// ==== source/ar_tracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module ar_tracker #(
	parameter int ID_W = rd_mon_pkg::MID_W
) (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          ar_valid,
	input  wire logic                          ar_ready,
	input  wire logic [ID_W-1:0]               ar_id,
	input  wire logic [rd_mon_pkg::ADDR_W-1:0] ar_addr,
	input  wire logic [2:0]                    ar_size,
	input  wire logic                          r_valid,
	input  wire logic                          r_ready,
	input  wire logic                          r_last,
	output logic                               beat_valid,
	output logic [rd_mon_pkg::ADDR_W-1:0]      beat_addr,
	output logic [rd_mon_pkg::LANES-1:0]       beat_mask,
	output logic [ID_W-1:0]                    beat_id,
	output logic                               ovf
);

	logic ar_hs;
	logic r_hs;
	logic full;
	logic push;
	logic pop;
	logic [rd_mon_pkg::TRK_PTR_W-1:0] wr_ptr;
	logic [rd_mon_pkg::TRK_PTR_W-1:0] rd_ptr;
	logic [rd_mon_pkg::TRK_PTR_W:0] count;
	logic [rd_mon_pkg::ADDR_W-1:0] q_addr [rd_mon_pkg::TRACK_DEPTH];
	logic [2:0] q_size [rd_mon_pkg::TRACK_DEPTH];
	logic [ID_W-1:0] q_id [rd_mon_pkg::TRACK_DEPTH];
	logic [2:0] head_size;
	logic [rd_mon_pkg::ADDR_W-1:0] run_addr;
	logic [rd_mon_pkg::ADDR_W-1:0] step;
	rd_mon_pkg::track_state_e state;

	assign ar_hs = ar_valid & ar_ready;
	assign r_hs = r_valid & r_ready;
	assign full = (count == rd_mon_pkg::TRACK_DEPTH);
	assign push = ar_hs & ~full;
	assign beat_valid = (count != '0);
	assign pop = r_hs & r_last & beat_valid; // Burst ends on last

	assign head_size = q_size[rd_ptr];
	assign beat_id = q_id[rd_ptr];
	assign beat_addr = (state == rd_mon_pkg::TRK_FIRST) ? q_addr[rd_ptr] : run_addr;
	assign step = {{(rd_mon_pkg::ADDR_W-1){1'b0}}, 1'b1} << head_size;

	// Lane active when it shares the size-aligned block of the address
	always_comb begin
		for (int i = 0; i < rd_mon_pkg::LANES; i++) begin
			beat_mask[i] = ((i >> head_size) ==
				(int'(beat_addr[rd_mon_pkg::LANE_W-1:0]) >> head_size));
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			q_addr[wr_ptr] <= ar_addr & ({rd_mon_pkg::ADDR_W{1'b1}} << ar_size);
			q_size[wr_ptr] <= ar_size;
			q_id[wr_ptr] <= ar_id;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			state <= rd_mon_pkg::TRK_FIRST;
			run_addr <= '0;
			ovf <= 1'b0;
		end else begin
			ovf <= ar_hs & full; // Request dropped
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (r_hs && beat_valid) begin
				if (r_last) begin
					state <= rd_mon_pkg::TRK_FIRST;
				end else begin
					state <= rd_mon_pkg::TRK_BURST;
					run_addr <= beat_addr + step; // INCR burst step
				end
			end
		end
	end

endmodule

`default_nettype wire

// ==== source/axi_rd_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rd_monitor (
	input  wire logic clk,
	input  wire logic rst_n,
	// Master side
	input  wire logic                          ar_valid_m,
	input  wire logic                          ar_ready_m,
	input  wire logic [rd_mon_pkg::MID_W-1:0]  ar_id_m,
	input  wire logic [rd_mon_pkg::ADDR_W-1:0] ar_addr_m,
	input  wire logic [2:0]                    ar_size_m,
	input  wire logic                          r_valid_m,
	input  wire logic                          r_ready_m,
	input  wire logic [rd_mon_pkg::MID_W-1:0]  r_id_m,
	input  wire logic [rd_mon_pkg::DATA_W-1:0] r_data_m,
	input  wire logic                          r_last_m,
	// Slave side
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0]                          ar_valid_s,
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0]                          ar_ready_s,
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::SID_W-1:0]   ar_id_s,
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::ADDR_W-1:0]  ar_addr_s,
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0][2:0]                     ar_size_s,
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0]                          r_valid_s,
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0]                          r_ready_s,
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::DATA_W-1:0]  r_data_s,
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0]                          r_last_s,
	// Config
	input  wire logic                          cfg_req,
	input  wire logic                          cfg_we,
	input  wire logic [rd_mon_pkg::CFG_AW-1:0] cfg_addr,
	input  wire logic [rd_mon_pkg::CFG_DW-1:0] cfg_wdata,
	output logic                               cfg_ack,
	output logic [rd_mon_pkg::CFG_DW-1:0]      cfg_rdata,
	output logic                               irq
);

	logic m_beat_valid;
	logic [rd_mon_pkg::ADDR_W-1:0] m_addr;
	logic [rd_mon_pkg::LANES-1:0] m_mask;
	logic [rd_mon_pkg::MID_W-1:0] m_arid;
	logic m_ovf;
	logic [rd_mon_pkg::N_SLAVES-1:0] s_beat_valid;
	logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::ADDR_W-1:0] s_addr;
	logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::LANES-1:0] s_mask;
	logic [rd_mon_pkg::N_SLAVES-1:0] s_trk_ovf;
	logic [rd_mon_pkg::N_SLAVES-1:0] buf_ovf;
	logic [rd_mon_pkg::N_SLAVES-1:0] head_valid;
	logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::ADDR_W-1:0] head_addr;
	logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::DATA_W-1:0] head_data;
	logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::LANES-1:0] head_mask;
	logic [rd_mon_pkg::N_SLAVES-1:0] pop;
	logic [rd_mon_pkg::ERR_W-1:0] cmp_err;
	logic [rd_mon_pkg::ERR_W-1:0] err_event;
	logic beat_done;
	logic enable;
	logic [rd_mon_pkg::SEL_LSB_W-1:0] sel_lsb;

	ar_tracker #(.ID_W(rd_mon_pkg::MID_W)) u_trk_m (
		.clk(clk), .rst_n(rst_n),
		.ar_valid(ar_valid_m), .ar_ready(ar_ready_m), .ar_id(ar_id_m),
		.ar_addr(ar_addr_m), .ar_size(ar_size_m),
		.r_valid(r_valid_m), .r_ready(r_ready_m), .r_last(r_last_m),
		.beat_valid(m_beat_valid), .beat_addr(m_addr), .beat_mask(m_mask),
		.beat_id(m_arid), .ovf(m_ovf)
	);

	for (genvar s = 0; s < rd_mon_pkg::N_SLAVES; s++) begin : g_slave
		// Slave IDs are remapped by the fabric, so beat_id stays open
		ar_tracker #(.ID_W(rd_mon_pkg::SID_W)) u_trk_s (
			.clk(clk), .rst_n(rst_n),
			.ar_valid(ar_valid_s[s]), .ar_ready(ar_ready_s[s]), .ar_id(ar_id_s[s]),
			.ar_addr(ar_addr_s[s]), .ar_size(ar_size_s[s]),
			.r_valid(r_valid_s[s]), .r_ready(r_ready_s[s]), .r_last(r_last_s[s]),
			.beat_valid(s_beat_valid[s]), .beat_addr(s_addr[s]), .beat_mask(s_mask[s]),
			.beat_id(), .ovf(s_trk_ovf[s])
		);

		slave_beat_buffer u_buf (
			.clk(clk), .rst_n(rst_n),
			.push(r_valid_s[s] & r_ready_s[s] & s_beat_valid[s]), // Tracked beats only
			.beat_addr(s_addr[s]), .beat_mask(s_mask[s]), .r_data(r_data_s[s]),
			.pop(pop[s]),
			.head_valid(head_valid[s]), .head_addr(head_addr[s]),
			.head_data(head_data[s]), .head_mask(head_mask[s]),
			.ovf(buf_ovf[s])
		);
	end

	beat_comparator u_cmp (
		.clk(clk), .rst_n(rst_n),
		.enable(enable), .sel_lsb(sel_lsb),
		.m_beat(r_valid_m & r_ready_m), .m_beat_valid(m_beat_valid),
		.m_addr(m_addr), .m_mask(m_mask), .m_data(r_data_m),
		.m_rid(r_id_m), .m_arid(m_arid),
		.head_valid(head_valid), .head_addr(head_addr),
		.head_data(head_data), .head_mask(head_mask),
		.pop(pop), .err_event(cmp_err), .beat_done(beat_done)
	);

	// Any queue overflow lands in ERR_OVF
	always_comb begin
		err_event = cmp_err;
		err_event[rd_mon_pkg::ERR_OVF] = m_ovf | (|s_trk_ovf) | (|buf_ovf);
	end

	mon_regs u_regs (
		.clk(clk), .rst_n(rst_n),
		.cfg_req(cfg_req), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata),
		.err_event(err_event), .beat_done(beat_done),
		.enable(enable), .sel_lsb(sel_lsb), .irq(irq)
	);

endmodule

`default_nettype wire

// ==== source/beat_comparator.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_comparator (
	input  wire logic                                  clk,
	input  wire logic                                  rst_n,
	input  wire logic                                  enable,
	input  wire logic [rd_mon_pkg::SEL_LSB_W-1:0]      sel_lsb,
	input  wire logic                                  m_beat,
	input  wire logic                                  m_beat_valid,
	input  wire logic [rd_mon_pkg::ADDR_W-1:0]         m_addr,
	input  wire logic [rd_mon_pkg::LANES-1:0]          m_mask,
	input  wire logic [rd_mon_pkg::DATA_W-1:0]         m_data,
	input  wire logic [rd_mon_pkg::MID_W-1:0]          m_rid,
	input  wire logic [rd_mon_pkg::MID_W-1:0]          m_arid,
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0]       head_valid,
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::ADDR_W-1:0] head_addr,
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::DATA_W-1:0] head_data,
	input  wire logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::LANES-1:0]  head_mask,
	output logic [rd_mon_pkg::N_SLAVES-1:0]            pop,
	output logic [rd_mon_pkg::ERR_W-1:0]               err_event,
	output logic                                       beat_done
);

	logic check;
	logic [rd_mon_pkg::SEL_W-1:0] sel;
	logic hit;
	logic [rd_mon_pkg::DATA_W-1:0] m_lanes;
	logic [rd_mon_pkg::ERR_W-1:0] err_nxt;

	assign check = m_beat & enable;
	assign sel = m_addr[sel_lsb +: rd_mon_pkg::SEL_W]; // Target slave field
	assign m_lanes = m_data & rd_mon_pkg::lane_bytes(m_mask);

	always_comb begin
		hit = m_beat_valid && head_valid[sel];
		pop = '0;
		err_nxt = '0;
		if (check) begin
			if (hit) begin
				pop[sel] = 1'b1;
				if (head_addr[sel] != m_addr || head_mask[sel] != m_mask ||
					head_data[sel] != m_lanes) begin
					err_nxt[rd_mon_pkg::ERR_DATA] = 1'b1;
				end
			end else begin
				// No slave beat, or no AR behind the master beat
				err_nxt[rd_mon_pkg::ERR_MISSING] = 1'b1;
			end
			if (m_beat_valid && m_rid != m_arid)
				err_nxt[rd_mon_pkg::ERR_ID] = 1'b1;
		end
	end

	// One cycle pulses after the master handshake
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			err_event <= '0;
			beat_done <= 1'b0;
		end else begin
			err_event <= err_nxt;
			beat_done <= check;
		end
	end

endmodule

`default_nettype wire

// ==== source/mon_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module mon_regs (
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic                             cfg_req,
	input  wire logic                             cfg_we,
	input  wire logic [rd_mon_pkg::CFG_AW-1:0]    cfg_addr,
	input  wire logic [rd_mon_pkg::CFG_DW-1:0]    cfg_wdata,
	output logic                                  cfg_ack,
	output logic [rd_mon_pkg::CFG_DW-1:0]         cfg_rdata,
	input  wire logic [rd_mon_pkg::ERR_W-1:0]     err_event,
	input  wire logic                             beat_done,
	output logic                                  enable,
	output logic [rd_mon_pkg::SEL_LSB_W-1:0]      sel_lsb,
	output logic                                  irq
);

	logic access;
	logic wr;
	rd_mon_pkg::reg_addr_e addr;
	logic [rd_mon_pkg::ERR_W-1:0] status;
	logic [rd_mon_pkg::ERR_W-1:0] clr;
	logic [rd_mon_pkg::ERR_W-1:0] status_nxt;
	logic [rd_mon_pkg::CFG_DW-1:0] beats;
	logic [rd_mon_pkg::CFG_DW-1:0] rd_val;

	// One access per request, taken while ack is still low
	assign access = cfg_req & ~cfg_ack;
	assign wr = access & cfg_we;
	assign addr = rd_mon_pkg::reg_addr_e'(cfg_addr);

	assign clr = (wr && addr == rd_mon_pkg::REG_STATUS) ?
		cfg_wdata[rd_mon_pkg::ERR_W-1:0] : '0;
	assign status_nxt = (status & ~clr) | err_event; // Set wins over clear

	always_comb begin
		rd_val = '0;
		case (addr)
			rd_mon_pkg::REG_CTRL: begin
				rd_val[rd_mon_pkg::CTRL_EN_BIT] = enable;
				rd_val[rd_mon_pkg::CTRL_SEL_LSB +: rd_mon_pkg::SEL_LSB_W] = sel_lsb;
			end
			rd_mon_pkg::REG_STATUS: rd_val[rd_mon_pkg::ERR_W-1:0] = status;
			rd_mon_pkg::REG_BEATS:  rd_val = beats;
			rd_mon_pkg::REG_ID:     rd_val = rd_mon_pkg::MON_ID;
			default:                rd_val = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (access)
			cfg_rdata <= rd_val; // Held while ack is high
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cfg_ack <= 1'b0;
			enable <= rd_mon_pkg::CTRL_EN_RST;
			sel_lsb <= rd_mon_pkg::SEL_LSB_RST;
			status <= '0;
			beats <= '0;
			irq <= 1'b0;
		end else begin
			if (access)
				cfg_ack <= 1'b1;
			else if (!cfg_req)
				cfg_ack <= 1'b0;

			if (wr && addr == rd_mon_pkg::REG_CTRL) begin
				enable <= cfg_wdata[rd_mon_pkg::CTRL_EN_BIT];
				sel_lsb <= cfg_wdata[rd_mon_pkg::CTRL_SEL_LSB +: rd_mon_pkg::SEL_LSB_W];
			end

			status <= status_nxt;
			irq <= |status_nxt;

			// Saturating count
			if (beat_done && beats != '1)
				beats <= beats + 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== source/rd_mon_pkg.sv ====
`default_nettype none

package rd_mon_pkg;

	// Bus geometry
	localparam int ADDR_W = 32;
	localparam int DATA_W = 64;
	localparam int LANES = DATA_W / 8;
	localparam int LANE_W = $clog2(LANES); // Byte offset bits inside a beat
	localparam int MID_W = 4;
	localparam int SID_W = 6;

	// Slave routing
	localparam int N_SLAVES = 2;
	localparam int SEL_W = 1;

	// Queue depths
	localparam int TRACK_DEPTH = 4;
	localparam int TRK_PTR_W = $clog2(TRACK_DEPTH);
	localparam int BEAT_DEPTH = 8;
	localparam int BEAT_PTR_W = $clog2(BEAT_DEPTH);

	// Config port
	localparam int CFG_AW = 2;
	localparam int CFG_DW = 32;

	typedef enum logic [CFG_AW-1:0] {
		REG_CTRL   = 2'd0,
		REG_STATUS = 2'd1, // W1C
		REG_BEATS  = 2'd2,
		REG_ID     = 2'd3
	} reg_addr_e;

	// CTRL fields
	localparam int CTRL_EN_BIT = 0;
	localparam logic CTRL_EN_RST = 1'b1;
	localparam int CTRL_SEL_LSB = 8;
	localparam int SEL_LSB_W = 5;
	localparam logic [SEL_LSB_W-1:0] SEL_LSB_RST = 5'd12;
	localparam logic [CFG_DW-1:0] MON_ID = 32'h5244_4d31;

	typedef enum logic {
		TRK_FIRST = 1'b0, // Next beat opens a burst
		TRK_BURST = 1'b1
	} track_state_e;

	// STATUS bits
	localparam int ERR_W = 4;
	localparam int ERR_DATA = 0;
	localparam int ERR_ID = 1;
	localparam int ERR_MISSING = 2;
	localparam int ERR_OVF = 3;

	// Byte lane mask to bit mask
	function automatic logic [DATA_W-1:0] lane_bytes(input logic [LANES-1:0] mask);
		logic [DATA_W-1:0] bytes;
		for (int i = 0; i < LANES; i++) begin
			bytes[i*8 +: 8] = {8{mask[i]}};
		end
		return bytes;
	endfunction

endpackage

`default_nettype wire

// ==== source/slave_beat_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module slave_beat_buffer (
	input  wire logic                          clk,
	input  wire logic                          rst_n,
	input  wire logic                          push,
	input  wire logic [rd_mon_pkg::ADDR_W-1:0] beat_addr,
	input  wire logic [rd_mon_pkg::LANES-1:0]  beat_mask,
	input  wire logic [rd_mon_pkg::DATA_W-1:0] r_data,
	input  wire logic                          pop,
	output logic                               head_valid,
	output logic [rd_mon_pkg::ADDR_W-1:0]      head_addr,
	output logic [rd_mon_pkg::DATA_W-1:0]      head_data,
	output logic [rd_mon_pkg::LANES-1:0]       head_mask,
	output logic                               ovf
);

	logic full;
	logic do_push;
	logic do_pop;
	logic [rd_mon_pkg::BEAT_PTR_W-1:0] wr_ptr;
	logic [rd_mon_pkg::BEAT_PTR_W-1:0] rd_ptr;
	logic [rd_mon_pkg::BEAT_PTR_W:0] count;
	logic [rd_mon_pkg::ADDR_W-1:0] q_addr [rd_mon_pkg::BEAT_DEPTH];
	logic [rd_mon_pkg::DATA_W-1:0] q_data [rd_mon_pkg::BEAT_DEPTH];
	logic [rd_mon_pkg::LANES-1:0] q_mask [rd_mon_pkg::BEAT_DEPTH];

	assign full = (count == rd_mon_pkg::BEAT_DEPTH);
	assign do_push = push & ~full;
	assign do_pop = pop & head_valid;

	assign head_valid = (count != '0);
	assign head_addr = q_addr[rd_ptr];
	assign head_data = q_data[rd_ptr];
	assign head_mask = q_mask[rd_ptr];

	always_ff @(posedge clk) begin
		if (do_push) begin
			q_addr[wr_ptr] <= beat_addr;
			q_data[wr_ptr] <= r_data & rd_mon_pkg::lane_bytes(beat_mask); // Idle lanes zeroed
			q_mask[wr_ptr] <= beat_mask;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			ovf <= 1'b0;
		end else begin
			ovf <= push & full;
			if (do_push)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

// ==== verification/axi_rd_monitor_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module axi_rd_monitor_checker (
	input wire logic                         clk,
	input wire logic                         rst_n,
	input wire logic                         cfg_req,
	input wire logic                         cfg_ack,
	input wire logic                         m_beat,
	input wire logic                         beat_done,
	input wire logic [rd_mon_pkg::ERR_W-1:0] status,
	input wire logic                         irq
);

	int unsigned fail_count = 0; // Read by the testbench summary

	ack_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(cfg_ack) |-> $past(cfg_req))
	else begin
		$error("cfg_ack rose without a pending request");
		fail_count++;
	end

	// Host holds req until ack is seen
	req_held_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(cfg_req) |-> cfg_ack)
	else begin
		$error("cfg_req dropped before cfg_ack rose");
		fail_count++;
	end

	done_follows_beat: assert property (@(posedge clk) disable iff (!rst_n)
		(beat_done && $past(beat_done)) |-> $past(m_beat))
	else begin
		$error("beat_done repeated without a master beat");
		fail_count++;
	end

	irq_low_when_clear: assert property (@(posedge clk) disable iff (!rst_n)
		(status == '0) |-> !irq)
	else begin
		$error("irq high while STATUS is clear");
		fail_count++;
	end

endmodule

bind axi_rd_monitor axi_rd_monitor_checker u_chk (
	.clk(clk),
	.rst_n(rst_n),
	.cfg_req(cfg_req),
	.cfg_ack(cfg_ack),
	.m_beat(r_valid_m & r_ready_m),
	.beat_done(beat_done),
	.status(u_regs.status),
	.irq(irq)
);

`default_nettype wire

// ==== verification/tb_axi_rd_monitor.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_rd_monitor;

	localparam int CLK_PERIOD = 4;
	localparam int CFG_WAIT = 16; // Cycles allowed for each handshake phase
	// Run length estimate
	localparam int N_CFG = 24;
	localparam int CFG_CYCLES = 8;
	localparam int N_BURSTS = 8;
	localparam int BURST_CYCLES = 7;
	localparam int N_BEATS = 12;
	localparam int MARGIN = 200;
	localparam int WATCHDOG_NS = CLK_PERIOD *
		(N_CFG * CFG_CYCLES + N_BURSTS * BURST_CYCLES + 2 * N_BEATS + MARGIN);

	logic clk;
	logic rst_n;
	logic ar_valid_m;
	logic ar_ready_m;
	logic [rd_mon_pkg::MID_W-1:0] ar_id_m;
	logic [rd_mon_pkg::ADDR_W-1:0] ar_addr_m;
	logic [2:0] ar_size_m;
	logic r_valid_m;
	logic r_ready_m;
	logic [rd_mon_pkg::MID_W-1:0] r_id_m;
	logic [rd_mon_pkg::DATA_W-1:0] r_data_m;
	logic r_last_m;
	logic [rd_mon_pkg::N_SLAVES-1:0] ar_valid_s;
	logic [rd_mon_pkg::N_SLAVES-1:0] ar_ready_s;
	logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::SID_W-1:0] ar_id_s;
	logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::ADDR_W-1:0] ar_addr_s;
	logic [rd_mon_pkg::N_SLAVES-1:0][2:0] ar_size_s;
	logic [rd_mon_pkg::N_SLAVES-1:0] r_valid_s;
	logic [rd_mon_pkg::N_SLAVES-1:0] r_ready_s;
	logic [rd_mon_pkg::N_SLAVES-1:0][rd_mon_pkg::DATA_W-1:0] r_data_s;
	logic [rd_mon_pkg::N_SLAVES-1:0] r_last_s;
	logic cfg_req;
	logic cfg_we;
	logic [rd_mon_pkg::CFG_AW-1:0] cfg_addr;
	logic [rd_mon_pkg::CFG_DW-1:0] cfg_wdata;
	logic cfg_ack;
	logic [rd_mon_pkg::CFG_DW-1:0] cfg_rdata;
	logic irq;

	int errors = 0;
	int tests_run = 0;
	int exp_beats = 0; // Compared beats expected in BEATS
	bit exp_enable = 1'b1;

	axi_rd_monitor u_dut (
		.clk(clk), .rst_n(rst_n),
		.ar_valid_m(ar_valid_m), .ar_ready_m(ar_ready_m), .ar_id_m(ar_id_m),
		.ar_addr_m(ar_addr_m), .ar_size_m(ar_size_m),
		.r_valid_m(r_valid_m), .r_ready_m(r_ready_m), .r_id_m(r_id_m),
		.r_data_m(r_data_m), .r_last_m(r_last_m),
		.ar_valid_s(ar_valid_s), .ar_ready_s(ar_ready_s), .ar_id_s(ar_id_s),
		.ar_addr_s(ar_addr_s), .ar_size_s(ar_size_s),
		.r_valid_s(r_valid_s), .r_ready_s(r_ready_s), .r_data_s(r_data_s),
		.r_last_s(r_last_s),
		.cfg_req(cfg_req), .cfg_we(cfg_we), .cfg_addr(cfg_addr), .cfg_wdata(cfg_wdata),
		.cfg_ack(cfg_ack), .cfg_rdata(cfg_rdata), .irq(irq)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired before the tests finished");
		$display("ERRORS FOUND");
		$finish;
	end

	task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string msg);
		if (got !== exp) begin
			$display("mismatch at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
			errors++;
		end
	endtask

	// Lanes of one beat from its aligned address and size
	function automatic logic [7:0] lane_mask(input logic [31:0] addr, input logic [2:0] size);
		logic [15:0] ones;
		ones = (16'd1 << (16'd1 << size)) - 16'd1;
		return 8'(ones[7:0] << addr[2:0]);
	endfunction

	task automatic cfg_access(input logic we, input logic [1:0] addr, input logic [31:0] wdata,
			output logic [31:0] rdata);
		int n;
		@(posedge clk);
		cfg_req <= 1'b1;
		cfg_we <= we;
		cfg_addr <= addr;
		cfg_wdata <= wdata;
		n = 0;
		@(posedge clk);
		while (!cfg_ack && n < CFG_WAIT) begin
			@(posedge clk);
			n++;
		end
		if (!cfg_ack) begin
			$display("cfg access at %0t ns: ack never rose", $time);
			errors++;
		end
		rdata = cfg_rdata;
		cfg_req <= 1'b0;
		n = 0;
		@(posedge clk);
		while (cfg_ack && n < CFG_WAIT) begin
			@(posedge clk);
			n++;
		end
		if (cfg_ack) begin
			$display("cfg access at %0t ns: ack never fell", $time);
			errors++;
		end
	endtask

	task automatic cfg_write(input logic [1:0] addr, input logic [31:0] wdata);
		logic [31:0] unused;
		cfg_access(1'b1, addr, wdata, unused);
	endtask

	task automatic cfg_read(input logic [1:0] addr, output logic [31:0] rdata);
		cfg_access(1'b0, addr, 32'h0, rdata);
	endtask

	task automatic expect_reg(input logic [1:0] addr, input logic [31:0] exp, input string msg);
		logic [31:0] val;
		cfg_read(addr, val);
		check_eq(64'(val), 64'(exp), msg);
	endtask

	// One burst, slave side first, then the master side
	task automatic read_burst(input int slv, input logic [3:0] arid, input logic [3:0] rid,
			input logic [31:0] addr, input logic [2:0] size, input int beats,
			input int bad_byte, input bit with_slave);
		logic [63:0] data [8];
		logic [63:0] mdata;
		logic [31:0] start;
		start = addr & ~((32'd1 << size) - 32'd1);
		for (int b = 0; b < beats; b++)
			data[b] = {$urandom, $urandom};
		@(posedge clk);
		ar_valid_m <= 1'b1;
		ar_id_m <= arid;
		ar_addr_m <= addr;
		ar_size_m <= size;
		if (with_slave) begin
			ar_valid_s[slv] <= 1'b1;
			ar_id_s[slv] <= {2'b10, arid}; // Fabric remaps the ID
			ar_addr_s[slv] <= addr;
			ar_size_s[slv] <= size;
		end
		@(posedge clk);
		ar_valid_m <= 1'b0;
		ar_valid_s <= '0;
		if (with_slave) begin
			for (int b = 0; b < beats; b++) begin
				r_valid_s[slv] <= 1'b1;
				r_data_s[slv] <= data[b];
				r_last_s[slv] <= (b == beats - 1);
				@(posedge clk);
			end
			r_valid_s <= '0;
			r_last_s <= '0;
		end
		for (int b = 0; b < beats; b++) begin
			mdata = data[b];
			if (b == 0 && bad_byte >= 0)
				mdata[bad_byte*8 +: 8] = ~mdata[bad_byte*8 +: 8];
			r_valid_m <= 1'b1;
			r_id_m <= rid;
			r_data_m <= mdata;
			r_last_m <= (b == beats - 1);
			@(negedge clk);
			check_eq(64'(u_dut.m_addr), 64'(start + (32'(b) << size)), "beat address");
			check_eq(64'(u_dut.m_mask), 64'(lane_mask(start + (32'(b) << size), size)),
				"beat lane mask");
			@(posedge clk);
		end
		r_valid_m <= 1'b0;
		r_last_m <= 1'b0;
		if (exp_enable)
			exp_beats += beats;
		repeat (4) @(posedge clk); // Let events reach STATUS
	endtask

	task automatic report_test(input string name, input int start);
		tests_run++;
		$display("test %s: %s, %0d failed checks", name,
			(errors == start) ? "passed" : "failed", errors - start);
	endtask

	task automatic test_reset_values();
		int start;
		start = errors;
		expect_reg(rd_mon_pkg::REG_CTRL, 32'h0000_0C01, "CTRL after reset"); // sel_lsb 12, on
		expect_reg(rd_mon_pkg::REG_STATUS, 32'h0, "STATUS after reset");
		expect_reg(rd_mon_pkg::REG_BEATS, 32'h0, "BEATS after reset");
		check_eq(64'(irq), 64'h0, "irq after reset");
		cfg_write(rd_mon_pkg::REG_CTRL, 32'h0000_0A01);
		expect_reg(rd_mon_pkg::REG_CTRL, 32'h0000_0A01, "CTRL readback");
		cfg_write(rd_mon_pkg::REG_CTRL, 32'h0000_0C01);
		report_test("reset_values", start);
	endtask

	task automatic test_matching_reads();
		int start;
		start = errors;
		read_burst(0, 4'h1, 4'h1, 32'h0000_0100, 3'd3, 1, -1, 1'b1);
		read_burst(0, 4'h2, 4'h2, 32'h0000_0206, 3'd2, 4, -1, 1'b1); // Aligns down to 0x204
		expect_reg(rd_mon_pkg::REG_STATUS, 32'h0, "STATUS after matching reads");
		expect_reg(rd_mon_pkg::REG_BEATS, 32'(exp_beats), "BEATS after matching reads");
		report_test("matching_reads", start);
	endtask

	task automatic test_corrupt_byte();
		int start;
		start = errors;
		// Halfword at 0x32 covers lanes 2 and 3
		read_burst(0, 4'h3, 4'h3, 32'h0000_0033, 3'd1, 1, 3, 1'b1);
		expect_reg(rd_mon_pkg::REG_STATUS, 32'd1 << rd_mon_pkg::ERR_DATA, "active lane");
		check_eq(64'(irq), 64'h1, "irq on data error");
		cfg_write(rd_mon_pkg::REG_STATUS, 32'hF);
		read_burst(0, 4'h3, 4'h3, 32'h0000_0033, 3'd1, 1, 6, 1'b1);
		expect_reg(rd_mon_pkg::REG_STATUS, 32'h0, "inactive lane");
		expect_reg(rd_mon_pkg::REG_BEATS, 32'(exp_beats), "BEATS after corrupt reads");
		report_test("corrupt_byte", start);
	endtask

	task automatic test_wrong_id();
		int start;
		start = errors;
		read_burst(0, 4'h5, 4'h6, 32'h0000_0400, 3'd3, 1, -1, 1'b1);
		expect_reg(rd_mon_pkg::REG_STATUS, 32'd1 << rd_mon_pkg::ERR_ID, "RID mismatch");
		cfg_write(rd_mon_pkg::REG_STATUS, 32'hF);
		report_test("wrong_id", start);
	endtask

	task automatic test_missing_and_clear();
		int start;
		start = errors;
		read_burst(0, 4'h7, 4'h7, 32'h0000_0500, 3'd3, 1, -1, 1'b0);
		expect_reg(rd_mon_pkg::REG_STATUS, 32'd1 << rd_mon_pkg::ERR_MISSING, "missing beat");
		check_eq(64'(irq), 64'h1, "irq on missing beat");
		cfg_write(rd_mon_pkg::REG_STATUS, 32'd1 << rd_mon_pkg::ERR_MISSING);
		expect_reg(rd_mon_pkg::REG_STATUS, 32'h0, "STATUS after clear");
		check_eq(64'(irq), 64'h0, "irq after clear");
		report_test("missing_and_clear", start);
	endtask

	task automatic test_routing_and_enable();
		int start;
		start = errors;
		cfg_write(rd_mon_pkg::REG_CTRL, 32'h0000_1001); // Select on bit 16
		read_burst(1, 4'h8, 4'h8, 32'h0001_0040, 3'd3, 2, -1, 1'b1);
		expect_reg(rd_mon_pkg::REG_STATUS, 32'h0, "routed to slave 1");
		expect_reg(rd_mon_pkg::REG_BEATS, 32'(exp_beats), "BEATS after routed read");
		cfg_write(rd_mon_pkg::REG_CTRL, 32'h0000_1000);
		exp_enable = 1'b0;
		read_burst(0, 4'h9, 4'h9, 32'h0000_0048, 3'd3, 1, 0, 1'b1);
		expect_reg(rd_mon_pkg::REG_STATUS, 32'h0, "STATUS while disabled");
		expect_reg(rd_mon_pkg::REG_BEATS, 32'(exp_beats), "BEATS while disabled");
		report_test("routing_and_enable", start);
	endtask

	initial begin
		void'($urandom(32'h5702));
		rst_n = 1'b0;
		ar_valid_m = 1'b0;
		ar_ready_m = 1'b1;
		ar_id_m = '0;
		ar_addr_m = '0;
		ar_size_m = '0;
		r_valid_m = 1'b0;
		r_ready_m = 1'b1;
		r_id_m = '0;
		r_data_m = '0;
		r_last_m = 1'b0;
		ar_valid_s = '0;
		ar_ready_s = '1;
		ar_id_s = '0;
		ar_addr_s = '0;
		ar_size_s = '0;
		r_valid_s = '0;
		r_ready_s = '1;
		r_data_s = '0;
		r_last_s = '0;
		cfg_req = 1'b0;
		cfg_we = 1'b0;
		cfg_addr = '0;
		cfg_wdata = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);
		test_reset_values();
		test_matching_reads();
		test_corrupt_byte();
		test_wrong_id();
		test_missing_and_clear();
		test_routing_and_enable();
		errors += int'(u_dut.u_chk.fail_count); // Assertion failures count too
		$display("tests run: %0d, failed checks: %0d", tests_run, errors);
		if (errors == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire
